// ==== Bender.yml ====
package:
  name: battleship

sources:
  - files:
      - battle_pkg.sv
      - board_cmd_if.sv
      - board_port_if.sv
      - game_status_if.sv
      - cmd_apb_slave.sv
      - game_flow.sv
      - game_board.sv
      - shot_reporter.sv
      - battleship_top.sv
  - target: test
    files:
      - tb_battleship.sv

// ==== battle_pkg.sv ====
// Shared encodings for the battleship rules core
// Cell coding follows the board store: 0 empty, 1 ship, 2 hit, 3 miss
// Coordinates are 3 bits each, fixed by the 8 by 8 board
// Player bit is 0 for the host and 1 for the guest everywhere
package battle_pkg;

    localparam int COORD_W = 3;

    localparam logic PLAYER_HOST  = 1'b0;
    localparam logic PLAYER_GUEST = 1'b1;

    typedef enum logic [1:0] {
        CELL_EMPTY = 2'd0,
        CELL_SHIP  = 2'd1,
        CELL_HIT   = 2'd2,
        CELL_MISS  = 2'd3
    } cell_t;

    typedef enum logic [1:0] {
        PH_PLACE_HOST  = 2'd0,
        PH_PLACE_GUEST = 2'd1,
        PH_BATTLE      = 2'd2,
        PH_OVER        = 2'd3
    } phase_t;

    // Code 3 is reserved and rejected as illegal
    typedef enum logic [1:0] {
        OP_PLACE    = 2'd0,
        OP_FIRE     = 2'd1,
        OP_NEW_GAME = 2'd2
    } op_t;

    typedef enum logic [2:0] {
        RES_NONE    = 3'd0,
        RES_PLACED  = 3'd1,
        RES_HIT     = 3'd2,
        RES_MISS    = 3'd3,
        RES_WIN     = 3'd4,
        RES_ILLEGAL = 3'd5
    } res_t;

    // Register byte offsets
    localparam logic [7:0] ADDR_CMD     = 8'h00;
    localparam logic [7:0] ADDR_STATUS  = 8'h04;
    localparam logic [7:0] ADDR_RESULT  = 8'h08;
    localparam logic [7:0] ADDR_STATS   = 8'h0C;
    localparam logic [7:0] ADDR_IRQ_CLR = 8'h10;

    // CMD fields
    localparam int CMD_COL_LSB = 0;
    localparam int CMD_ROW_LSB = 3;
    localparam int CMD_OP_LSB  = 8;

    // STATUS fields
    localparam int ST_PHASE_LSB = 0;
    localparam int ST_TURN_BIT  = 4;
    localparam int ST_HOST_LSB  = 8;
    localparam int ST_GUEST_LSB = 16;

    // RESULT fields
    localparam int RS_CODE_LSB   = 0;
    localparam int RS_PLAYER_BIT = 4;
    localparam int RS_COL_LSB    = 8;
    localparam int RS_ROW_LSB    = 12;
    localparam int RS_IRQ_BIT    = 31;

    // STATS bytes, low byte first
    localparam int SS_HOST_SHOTS_LSB  = 0;
    localparam int SS_GUEST_SHOTS_LSB = 8;
    localparam int SS_HOST_HITS_LSB   = 16;
    localparam int SS_GUEST_HITS_LSB  = 24;

endpackage

// ==== battleship_top.sv ====
// Battleship rules core with an APB register interface
// Single clock domain, asynchronous active-high reset
// SHIPS_PER_PLAYER sets the placement budget, 1 to 64
`timescale 1ns/100ps

module battleship_top import battle_pkg::*; #(
    parameter int SHIPS_PER_PLAYER = 10
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        irq
);

    board_cmd_if   u_cmd_if ();
    board_port_if  u_port_if ();
    game_status_if u_status_if ();

    // Result path from the controller to the reporter
    logic               res_valid;
    res_t               res_code;
    logic               res_player;
    logic [COORD_W-1:0] res_row;
    logic [COORD_W-1:0] res_col;

    logic [31:0] result_word;
    logic [31:0] stats_word;
    logic        irq_clr;

    cmd_apb_slave u_cmd_apb_slave (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .cmd         (u_cmd_if.src),
        .status      (u_status_if.sink),
        .result_word (result_word),
        .stats_word  (stats_word),
        .irq_clr     (irq_clr)
    );

    game_flow #(
        .SHIPS_PER_PLAYER (SHIPS_PER_PLAYER)
    ) u_game_flow (
        .clk        (clk),
        .rst        (rst),
        .cmd        (u_cmd_if.dst),
        .board      (u_port_if.ctrl),
        .status     (u_status_if.source),
        .res_valid  (res_valid),
        .res_code   (res_code),
        .res_player (res_player),
        .res_row    (res_row),
        .res_col    (res_col)
    );

    game_board u_game_board (
        .clk  (clk),
        .rst  (rst),
        .port (u_port_if.mem)
    );

    shot_reporter u_shot_reporter (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (res_valid),
        .res_code    (res_code),
        .res_player  (res_player),
        .res_row     (res_row),
        .res_col     (res_col),
        .irq_clr     (irq_clr),
        .result_word (result_word),
        .stats_word  (stats_word),
        .irq         (irq)
    );

endmodule

// ==== board_cmd_if.sv ====
// Decoded command from the register block to the game controller
// valid is a single-cycle pulse; the receiver takes every pulse
`timescale 1ns/100ps

interface board_cmd_if import battle_pkg::*; ();

    logic               valid;
    op_t                op;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;

    modport src (
        output valid, op, row, col
    );

    modport dst (
        input valid, op, row, col
    );

endinterface

// ==== board_port_if.sv ====
// Access port into the two-board cell store
// rd_cell is combinational on player, row and col
// we and clear act on the next clock edge, clear has priority
`timescale 1ns/100ps

interface board_port_if import battle_pkg::*; ();

    logic               player;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;
    cell_t              rd_cell;
    logic               we;
    cell_t              wr_cell;
    logic               clear;

    modport ctrl (
        output player, row, col, we, wr_cell, clear,
        input  rd_cell
    );

    modport mem (
        input  player, row, col, we, wr_cell, clear,
        output rd_cell
    );

endinterface

// ==== cmd_apb_slave.sv ====
// APB register block of the rules core
// pready is tied high; every command finishes before the next transfer
// Only the exact offsets in battle_pkg are decoded, anything else is an error
// Commands and irq clears are registered single-cycle pulses
`timescale 1ns/100ps

module cmd_apb_slave import battle_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    board_cmd_if.src    cmd,
    game_status_if.sink status,
    input  logic [31:0] result_word,
    input  logic [31:0] stats_word,
    output logic        irq_clr
);

    logic        access;
    logic        wr_ok;
    logic        rd_ok;
    logic        cmd_wr;
    logic [31:0] status_word;

    assign access = psel & penable;
    assign cmd_wr = access & pwrite & (paddr == ADDR_CMD);

    // Which offsets accept which direction
    always_comb begin
        wr_ok = 1'b0;
        rd_ok = 1'b0;
        case (paddr)
            ADDR_CMD, ADDR_IRQ_CLR:              wr_ok = 1'b1;
            ADDR_STATUS, ADDR_RESULT, ADDR_STATS: rd_ok = 1'b1;
            default: ;
        endcase
    end

    assign pready  = 1'b1;
    assign pslverr = access & (pwrite ? ~wr_ok : ~rd_ok);

    always_comb begin
        status_word = '0;
        status_word[ST_PHASE_LSB +: 2] = status.phase;
        status_word[ST_TURN_BIT]       = status.turn;
        status_word[ST_HOST_LSB +: 8]  = status.host_left;
        status_word[ST_GUEST_LSB +: 8] = status.guest_left;
    end

    always_comb begin
        case (paddr)
            ADDR_STATUS: prdata = status_word;
            ADDR_RESULT: prdata = result_word;
            ADDR_STATS:  prdata = stats_word;
            default:     prdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd.valid <= 1'b0;
            irq_clr   <= 1'b0;
        end else begin
            cmd.valid <= cmd_wr;
            irq_clr   <= access & pwrite & (paddr == ADDR_IRQ_CLR);
        end
    end

    // Command fields, only meaningful while valid is high
    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            cmd.op  <= op_t'(pwdata[CMD_OP_LSB +: 2]);
            cmd.row <= pwdata[CMD_ROW_LSB +: COORD_W];
            cmd.col <= pwdata[CMD_COL_LSB +: COORD_W];
        end
    end

endmodule

// ==== game_board.sv ====
// Cell store for both players, 8 by 8 cells of cell_t each
// Same row/column coordinates as the commands, index 0 is the host
// Read is combinational; write and clear land on the next edge
`timescale 1ns/100ps

module game_board import battle_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    board_port_if.mem port
);

    localparam int SIDE = 1 << COORD_W;

    cell_t cells [2][SIDE][SIDE];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cells <= '{default: CELL_EMPTY};
        end else if (port.clear) begin
            // New game wipes both boards at once
            cells <= '{default: CELL_EMPTY};
        end else if (port.we) begin
            cells[port.player][port.row][port.col] <= port.wr_cell;
        end
    end

    assign port.rd_cell = cells[port.player][port.row][port.col];

endmodule

// ==== game_flow.sv ====
// Game controller: placement and firing rules, turn order, game over
// Reads the addressed cell combinationally in the command cycle and
// commits board, state and result at the following edge
// Ships are single cells; SHIPS_PER_PLAYER from 1 to 64
`timescale 1ns/100ps

module game_flow import battle_pkg::*; #(
    parameter int SHIPS_PER_PLAYER = 10
) (
    input  logic               clk,
    input  logic               rst,
    board_cmd_if.dst           cmd,
    board_port_if.ctrl         board,
    game_status_if.source      status,
    output logic               res_valid,
    output res_t               res_code,
    output logic               res_player,
    output logic [COORD_W-1:0] res_row,
    output logic [COORD_W-1:0] res_col
);

    localparam logic [7:0] SHIP_CNT = 8'(SHIPS_PER_PLAYER);

    phase_t     phase;
    logic       turn;
    logic [7:0] left [2];

    logic       placer;
    logic       target;
    logic       who;
    logic       legal;
    res_t       code;
    cell_t      next_cell;

    always_comb begin
        placer = (phase == PH_PLACE_GUEST) ? PLAYER_GUEST : PLAYER_HOST;
        // Fire aims at the opponent's board, place at the placer's own
        target = (cmd.op == OP_FIRE) ? ~turn : placer;
        case (cmd.op)
            OP_FIRE:  who = turn;
            OP_PLACE: who = placer;
            default:  who = PLAYER_HOST;
        endcase
    end

    // Rule check on the addressed cell
    always_comb begin
        legal     = 1'b0;
        code      = RES_ILLEGAL;
        next_cell = CELL_SHIP;
        case (cmd.op)
            OP_NEW_GAME: begin
                legal = 1'b1;
                code  = RES_NONE;
            end
            OP_PLACE: begin
                if ((phase == PH_PLACE_HOST || phase == PH_PLACE_GUEST) &&
                    board.rd_cell == CELL_EMPTY) begin
                    legal = 1'b1;
                    code  = RES_PLACED;
                end
            end
            OP_FIRE: begin
                if (phase == PH_BATTLE && board.rd_cell == CELL_SHIP) begin
                    legal     = 1'b1;
                    next_cell = CELL_HIT;
                    code      = (left[target] == 8'd1) ? RES_WIN : RES_HIT;
                end else if (phase == PH_BATTLE && board.rd_cell == CELL_EMPTY) begin
                    legal     = 1'b1;
                    next_cell = CELL_MISS;
                    code      = RES_MISS;
                end
            end
            default: ;
        endcase
    end

    assign board.player  = target;
    assign board.row     = cmd.row;
    assign board.col     = cmd.col;
    assign board.wr_cell = next_cell;
    assign board.we      = cmd.valid & legal & (cmd.op == OP_PLACE || cmd.op == OP_FIRE);
    assign board.clear   = cmd.valid & (cmd.op == OP_NEW_GAME);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase     <= PH_PLACE_HOST;
            turn      <= PLAYER_HOST;
            left      <= '{default: '0};
            res_valid <= 1'b0;
        end else begin
            res_valid <= cmd.valid;
            if (cmd.valid && legal) begin
                case (cmd.op)
                    OP_NEW_GAME: begin
                        phase <= PH_PLACE_HOST;
                        turn  <= PLAYER_HOST;
                        left  <= '{default: '0};
                    end
                    OP_PLACE: begin
                        left[placer] <= left[placer] + 8'd1;
                        // Budget reached, hand over to the next phase
                        if (left[placer] + 8'd1 == SHIP_CNT)
                            phase <= (placer == PLAYER_GUEST) ? PH_BATTLE : PH_PLACE_GUEST;
                    end
                    OP_FIRE: begin
                        turn <= ~turn;
                        if (next_cell == CELL_HIT)
                            left[target] <= left[target] - 8'd1;
                        if (code == RES_WIN)
                            phase <= PH_OVER;
                    end
                    default: ;
                endcase
            end
        end
    end

    // Result payload, qualified by res_valid
    always_ff @(posedge clk) begin
        if (cmd.valid) begin
            res_code   <= code;
            res_player <= who;
            res_row    <= cmd.row;
            res_col    <= cmd.col;
        end
    end

    assign status.phase      = phase;
    assign status.turn       = turn;
    assign status.host_left  = left[PLAYER_HOST];
    assign status.guest_left = left[PLAYER_GUEST];

endmodule

// ==== game_status_if.sv ====
// Game state seen by the register block
// Counts are ship cells still standing, one byte per player
`timescale 1ns/100ps

interface game_status_if import battle_pkg::*; ();

    phase_t     phase;
    logic       turn;
    logic [7:0] host_left;
    logic [7:0] guest_left;

    modport source (
        output phase, turn, host_left, guest_left
    );

    modport sink (
        input phase, turn, host_left, guest_left
    );

endinterface

// ==== shot_reporter.sv ====
// Last result latch, shot and hit statistics, interrupt
// Counters are 8 bits and wrap; a winning shot counts as a hit
// A RES_NONE result (new game) zeroes all counters
// irq set beats a clear arriving in the same cycle
`timescale 1ns/100ps

module shot_reporter import battle_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               res_valid,
    input  res_t               res_code,
    input  logic               res_player,
    input  logic [COORD_W-1:0] res_row,
    input  logic [COORD_W-1:0] res_col,
    input  logic               irq_clr,
    output logic [31:0]        result_word,
    output logic [31:0]        stats_word,
    output logic               irq
);

    res_t               last_code;
    logic               last_player;
    logic [COORD_W-1:0] last_row;
    logic [COORD_W-1:0] last_col;
    logic [7:0]         shots [2];
    logic [7:0]         hits [2];
    logic               is_shot;
    logic               is_hit;

    assign is_shot = res_code inside {RES_HIT, RES_MISS, RES_WIN};
    assign is_hit  = res_code inside {RES_HIT, RES_WIN};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_code   <= RES_NONE;
            last_player <= PLAYER_HOST;
            last_row    <= '0;
            last_col    <= '0;
            shots       <= '{default: '0};
            hits        <= '{default: '0};
            irq         <= 1'b0;
        end else begin
            if (res_valid) begin
                last_code   <= res_code;
                last_player <= res_player;
                last_row    <= res_row;
                last_col    <= res_col;
                if (res_code == RES_NONE) begin
                    shots <= '{default: '0};
                    hits  <= '{default: '0};
                end else if (is_shot) begin
                    shots[res_player] <= shots[res_player] + 8'd1;
                    if (is_hit)
                        hits[res_player] <= hits[res_player] + 8'd1;
                end
            end
            if (res_valid && (res_code == RES_WIN || res_code == RES_ILLEGAL))
                irq <= 1'b1;
            else if (irq_clr)
                irq <= 1'b0;
        end
    end

    always_comb begin
        result_word = '0;
        result_word[RS_CODE_LSB +: 3]       = last_code;
        result_word[RS_PLAYER_BIT]          = last_player;
        result_word[RS_COL_LSB +: COORD_W]  = last_col;
        result_word[RS_ROW_LSB +: COORD_W]  = last_row;
        result_word[RS_IRQ_BIT]             = irq;
    end

    always_comb begin
        stats_word = '0;
        stats_word[SS_HOST_SHOTS_LSB +: 8]  = shots[PLAYER_HOST];
        stats_word[SS_GUEST_SHOTS_LSB +: 8] = shots[PLAYER_GUEST];
        stats_word[SS_HOST_HITS_LSB +: 8]   = hits[PLAYER_HOST];
        stats_word[SS_GUEST_HITS_LSB +: 8]  = hits[PLAYER_GUEST];
    end

endmodule

// ==== sim.f ====
battle_pkg.sv
board_cmd_if.sv
board_port_if.sv
game_status_if.sv
cmd_apb_slave.sv
game_flow.sv
game_board.sv
shot_reporter.sv
battleship_top.sv
tb_battleship.sv

// ==== tb_battleship.sv ====
// Testbench for the battleship rules core with SHIPS_PER_PLAYER set to 10
// Random command stream from a fixed seed checked against a reference model
// APB inputs change 1 ns after the rising edge
// Outputs are sampled at the falling edge
// One idle cycle after each command lets the result reach the RESULT and STATS registers
`timescale 1ns/100ps

module tb_battleship import battle_pkg::*; ();

    localparam int SHIPS      = 10;
    localparam int WAIT_LIMIT = 20;

    logic        clk;
    logic        rst;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    int errors;
    int checks;

    // Reference model state
    int mcell [2][8][8];
    int mphase;
    int mturn;
    int mirq;
    int mcode;
    int mplayer;
    int mrow;
    int mcol;
    int mleft [2];
    int mshots [2];
    int mhits [2];

    battleship_top #(
        .SHIPS_PER_PLAYER (SHIPS)
    ) u_battleship_top (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #4 clk = ~clk;

    task automatic end_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Waits for pready in the access phase and then releases the bus
    task automatic finish_transfer(output logic [31:0] data, output logic err);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (pready !== 1'b1 && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (pready !== 1'b1) begin
            errors++;
            $display("Timeout: pready did not rise for the transfer at offset %h", paddr);
            end_run();
        end else begin
            data = prdata;
            err  = pslverr;
            @(posedge clk);
            #1;
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data, output logic err);
        logic [31:0] unused;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        finish_transfer(unused, err);
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        finish_transfer(data, err);
    endtask

    function automatic logic [31:0] status_exp();
        status_exp = {8'd0, mleft[1][7:0], mleft[0][7:0], 3'd0, mturn[0], 2'd0, mphase[1:0]};
    endfunction

    function automatic logic [31:0] result_exp();
        result_exp = {mirq[0], 16'd0, mrow[2:0], 1'b0, mcol[2:0], 3'd0, mplayer[0], 1'b0,
                      mcode[2:0]};
    endfunction

    function automatic logic [31:0] stats_exp();
        stats_exp = {mhits[1][7:0], mhits[0][7:0], mshots[1][7:0], mshots[0][7:0]};
    endfunction

    // Game rules applied to the model
    task automatic model_apply(int op, int row, int col);
        int placer;
        int tgt;
        mcode   = RES_ILLEGAL;
        mplayer = 0;
        mrow    = row;
        mcol    = col;
        case (op)
            OP_NEW_GAME: begin
                mcell  = '{default: 0};
                mphase = PH_PLACE_HOST;
                mturn  = 0;
                mleft  = '{0, 0};
                mshots = '{0, 0};
                mhits  = '{0, 0};
                mcode  = RES_NONE;
            end
            OP_PLACE: begin
                placer  = (mphase == PH_PLACE_GUEST) ? 1 : 0;
                mplayer = placer;
                if ((mphase == PH_PLACE_HOST || mphase == PH_PLACE_GUEST) &&
                    mcell[placer][row][col] == CELL_EMPTY) begin
                    mcell[placer][row][col] = CELL_SHIP;
                    mleft[placer]++;
                    mcode = RES_PLACED;
                    if (mleft[placer] == SHIPS)
                        mphase = placer ? PH_BATTLE : PH_PLACE_GUEST;
                end
            end
            OP_FIRE: begin
                mplayer = mturn;
                tgt     = 1 - mturn;
                if (mphase == PH_BATTLE && mcell[tgt][row][col] == CELL_SHIP) begin
                    mcell[tgt][row][col] = CELL_HIT;
                    mleft[tgt]--;
                    mhits[mturn]++;
                    mshots[mturn]++;
                    mcode = (mleft[tgt] == 0) ? RES_WIN : RES_HIT;
                    if (mleft[tgt] == 0)
                        mphase = PH_OVER;
                    mturn = 1 - mturn;
                end else if (mphase == PH_BATTLE && mcell[tgt][row][col] == CELL_EMPTY) begin
                    mcell[tgt][row][col] = CELL_MISS;
                    mshots[mturn]++;
                    mcode = RES_MISS;
                    mturn = 1 - mturn;
                end
            end
            default: ;
        endcase
        if (mcode == RES_WIN || mcode == RES_ILLEGAL)
            mirq = 1;
    endtask

    task automatic read_check(string name, logic [7:0] addr, logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_value(name, exp, data);
        check_value({name, " pslverr"}, 32'd0, {31'd0, err});
    endtask

    task automatic check_regs(string name);
        read_check({name, "/STATUS"}, ADDR_STATUS, status_exp());
        read_check({name, "/RESULT"}, ADDR_RESULT, result_exp());
        read_check({name, "/STATS"}, ADDR_STATS, stats_exp());
        check_value({name, "/irq"}, mirq, {31'd0, irq});
    endtask

    task automatic send_cmd(string name, int op, int row, int col);
        logic err;
        apb_write(ADDR_CMD, {22'd0, op[1:0], 2'd0, row[2:0], col[2:0]}, err);
        check_value({name, "/CMD pslverr"}, 32'd0, {31'd0, err});
        model_apply(op, row, col);
        @(posedge clk);
        #1;
        check_regs(name);
    endtask

    task automatic clear_irq(string name);
        logic err;
        apb_write(ADDR_IRQ_CLR, 32'h1, err);
        check_value({name, "/IRQ_CLR pslverr"}, 32'd0, {31'd0, err});
        mirq = 0;
        @(posedge clk);
        #1;
        check_regs(name);
    endtask

    // Access that must fail with pslverr and leave all state alone
    task automatic bad_access(string name, logic [7:0] addr, bit write);
        logic [31:0] data;
        logic        err;
        if (write)
            apb_write(addr, $urandom, err);
        else
            apb_read(addr, data, err);
        check_value({name, "/pslverr"}, 32'd1, {31'd0, err});
        @(posedge clk);
        #1;
        check_regs(name);
    endtask

    initial begin
        int r;
        int op;
        int row;
        int col;
        int n;
        int ship_cells [$];
        clk     = 1'b0;
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        errors  = 0;
        checks  = 0;
        r = $urandom(32'h971c);
        model_apply(OP_NEW_GAME, 0, 0);
        mirq = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_regs("reset");

        send_cmd("fire_in_place", OP_FIRE, 2, 5);
        send_cmd("reserved_op", 3, 1, 1);
        clear_irq("irq_clear");

        // A quarter of the placement commands reuse the last cell
        row = 0;
        col = 0;
        n   = 0;
        while (mphase != PH_BATTLE && n < 400) begin
            r = $urandom % 16;
            if (r >= 4) begin
                row = $urandom % 8;
                col = $urandom % 8;
            end
            op = (r == 0) ? OP_FIRE : (r == 1) ? 3 : OP_PLACE;
            send_cmd("place", op, row, col);
            if (mirq != 0 && $urandom % 4 == 0)
                clear_irq("place_irq");
            n++;
        end
        assert (mphase == PH_BATTLE) else begin
            errors++;
            $display("Placement did not reach the battle phase within %0d commands", n);
        end

        // An empty host cell leaves the phase as the only reason to reject
        n = 0;
        while (n < 63 && mcell[0][n / 8][n % 8] != CELL_EMPTY)
            n++;
        send_cmd("place_in_battle", OP_PLACE, n / 8, n % 8);
        n = 0;
        while (mphase != PH_OVER && n < 3000) begin
            r   = $urandom % 16;
            row = $urandom % 8;
            col = $urandom % 8;
            op  = (r == 0) ? OP_PLACE : (r == 1) ? 3 : OP_FIRE;
            send_cmd("battle", op, row, col);
            if (mirq != 0 && r == 2)
                clear_irq("battle_irq");
            n++;
        end
        assert (mphase == PH_OVER) else begin
            errors++;
            $display("Battle did not end in a win within %0d commands", n);
        end

        // An unshot target cell leaves the phase as the only reason to reject
        n = 0;
        while (n < 63 && (mcell[1 - mturn][n / 8][n % 8] == CELL_HIT ||
                          mcell[1 - mturn][n / 8][n % 8] == CELL_MISS))
            n++;
        send_cmd("fire_after_win", OP_FIRE, n / 8, n % 8);
        clear_irq("win_irq_clear");

        bad_access("write_status", ADDR_STATUS, 1'b1);
        bad_access("read_cmd", ADDR_CMD, 1'b0);
        bad_access("read_irq_clr", ADDR_IRQ_CLR, 1'b0);
        bad_access("write_unknown", 8'h14, 1'b1);
        bad_access("read_unknown", 8'h02, 1'b0);

        // Old ship cells of both boards must take a ship again after the new game
        for (r = 0; r < 2; r++) begin
            for (n = 0; n < 64; n++) begin
                if (mcell[r][n / 8][n % 8] == CELL_SHIP || mcell[r][n / 8][n % 8] == CELL_HIT)
                    ship_cells.push_back(n);
            end
        end
        send_cmd("new_game", OP_NEW_GAME, 4, 6);
        foreach (ship_cells[i])
            send_cmd("place_after_new", OP_PLACE, ship_cells[i] / 8, ship_cells[i] % 8);
        end_run();
    end

endmodule
